//--- llc_hit_miss.f
+incdir+verification
src/llc_hit_miss_pkg.sv
src/llc_stage_if.sv
src/llc_desc_intake.sv
src/llc_tag_store.sv
src/llc_line_lock.sv
src/llc_miss_counters.sv
src/llc_dispatch.sv
src/llc_hit_miss.sv
verification/llc_hit_miss_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the hit/miss stage testbench with Verilator.
# Exit status is 0 only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -Wno-fatal --top-module llc_hit_miss_tb \
  -f llc_hit_miss.f --Mdir obj_dir -o llc_hit_miss_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/llc_hit_miss_sim > "$log" 2>&1
status=$?
cat "$log"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "sim passed" "$log"; then
  exit 0
fi
echo "pass line not found in $log"
exit 1

//--- src/llc_desc_intake.sv
/*
  One-entry descriptor register in front of the tag store.
  Input ready follows the tag store's ready, so the tag clear and any
  downstream stall close the input without extra logic.
*/
`timescale 1ns/10ps
`default_nettype none

module llc_desc_intake (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    valid_i,
  input  llc_hit_miss_pkg::desc_t desc_i,
  output logic                    ready_o,
  llc_req_if.source               req_o
);
  import llc_hit_miss_pkg::*;

  // entry state
  logic  full_q;
  desc_t desc_q;
  logic  in_xfer;

  // a full entry can be replaced in the same cycle it leaves,
  // an empty one is filled whenever the tag store could take it next
  assign ready_o = req_o.ready;
  assign in_xfer = valid_i & ready_o;

  // offer the held descriptor
  assign req_o.valid = full_q;
  assign req_o.desc  = desc_q;

  //////////////////////////////
  // occupancy
  //////////////////////////////
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      full_q <= 1'b0;
    end else if (in_xfer) begin
      // fill, or leave and refill at once
      full_q <= 1'b1;
    end else if (req_o.ready) begin
      // entry handed over, nothing new
      full_q <= 1'b0;
    end
  end

  // payload only moves on an accepted input
  always_ff @(posedge clk_i) begin
    if (in_xfer) begin
      desc_q <= desc_i;
    end
  end

endmodule

`default_nettype wire

//--- src/llc_dispatch.sv
/*
  Routes a looked-up descriptor to the hit or miss port. A result waits
  while its line is locked or its ID counter is full. Purely combinational.
*/
`timescale 1ns/10ps
`default_nettype none

module llc_dispatch (
  llc_res_if.sink                    res_i,
  input  logic                       hit_ready_i,
  input  logic                       miss_ready_i,
  output logic                       hit_valid_o,
  output logic                       miss_valid_o,
  output llc_hit_miss_pkg::result_t  res_o,
  input  logic                       locked_i,
  input  logic                       to_miss_i,
  input  logic                       stall_i,
  output logic                       lock_req_o,
  output llc_hit_miss_pkg::index_t   lock_index_o,
  output llc_hit_miss_pkg::way_ind_t lock_way_o,
  output logic                       cnt_up_o,
  output llc_hit_miss_pkg::id_t      cnt_up_id_o
);
  import llc_hit_miss_pkg::*;

  logic hold;
  logic use_hit;
  logic hit_xfer;
  logic miss_xfer;

  // line and id of the waiting result go out for the lock and counter checks
  assign lock_index_o = res_i.res.desc.addr[offset_width +: index_width];
  assign lock_way_o   = res_i.res.way_ind;
  assign cnt_up_id_o  = res_i.res.desc.id;

  assign hold = locked_i | stall_i;

  // hits whose ID still has misses in flight keep order via the miss port
  assign use_hit = res_i.res.hit & ~to_miss_i;

  //////////////////////////////
  // port handshake
  //////////////////////////////
  assign hit_valid_o  = res_i.valid & ~hold & use_hit;
  assign miss_valid_o = res_i.valid & ~hold & ~use_hit;

  assign hit_xfer  = hit_valid_o & hit_ready_i;
  assign miss_xfer = miss_valid_o & miss_ready_i;

  // free the result register, lock the line, track miss occupancy
  assign res_i.ready = hit_xfer | miss_xfer;
  assign lock_req_o  = hit_xfer | miss_xfer;
  assign cnt_up_o    = miss_xfer;

  assign res_o = res_i.res;

endmodule

`default_nettype wire

//--- src/llc_hit_miss.sv
/*
  Hit/miss stage of the last-level cache. Input is refused during the
  tag clear after reset. Hit and miss ports share one result bus.
*/
`timescale 1ns/10ps
`default_nettype none

module llc_hit_miss #(
  parameter int unsigned num_sets = 2 ** llc_hit_miss_pkg::index_width,
  parameter int unsigned num_ways = llc_hit_miss_pkg::num_ways,
  parameter int unsigned num_ids  = 2 ** llc_hit_miss_pkg::id_width
) (
  input  logic                       clk_i,
  input  logic                       rst_i,
  // descriptor input
  input  logic                       valid_i,
  output logic                       ready_o,
  input  llc_hit_miss_pkg::addr_t    addr_i,
  input  llc_hit_miss_pkg::id_t      id_i,
  input  logic                       rw_i,
  // result ports
  output logic                       hit_valid_o,
  input  logic                       hit_ready_i,
  output logic                       miss_valid_o,
  input  logic                       miss_ready_i,
  output llc_hit_miss_pkg::addr_t    out_addr_o,
  output llc_hit_miss_pkg::id_t      out_id_o,
  output logic                       out_rw_o,
  output llc_hit_miss_pkg::way_ind_t way_ind_o,
  output logic                       refill_o,
  output logic                       evict_o,
  output llc_hit_miss_pkg::tag_t     evict_tag_o,
  // line unlock and miss count-down
  input  logic                       unlock_valid_i,
  input  llc_hit_miss_pkg::index_t   unlock_index_i,
  input  llc_hit_miss_pkg::way_ind_t unlock_way_i,
  input  logic                       cnt_down_valid_i,
  input  llc_hit_miss_pkg::id_t      cnt_down_id_i
);
  import llc_hit_miss_pkg::*;

  desc_t    in_desc;
  result_t  out_res;
  logic     lock_req;
  logic     locked;
  index_t   lock_index;
  way_ind_t lock_way;
  logic     cnt_up;
  id_t      cnt_up_id;
  logic     to_miss;
  logic     cnt_stall;

  llc_req_if req_if ();
  llc_res_if res_if ();

  assign in_desc = '{addr: addr_i, id: id_i, rw: rw_i};

  llc_desc_intake i_desc_intake (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (valid_i),
    .desc_i  (in_desc),
    .ready_o (ready_o),
    .req_o   (req_if)
  );

  llc_tag_store #(
    .num_sets (num_sets),
    .num_ways (num_ways)
  ) i_tag_store (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .req_i (req_if),
    .res_o (res_if)
  );

  llc_dispatch i_dispatch (
    .res_i        (res_if),
    .hit_ready_i  (hit_ready_i),
    .miss_ready_i (miss_ready_i),
    .hit_valid_o  (hit_valid_o),
    .miss_valid_o (miss_valid_o),
    .res_o        (out_res),
    .locked_i     (locked),
    .to_miss_i    (to_miss),
    .stall_i      (cnt_stall),
    .lock_req_o   (lock_req),
    .lock_index_o (lock_index),
    .lock_way_o   (lock_way),
    .cnt_up_o     (cnt_up),
    .cnt_up_id_o  (cnt_up_id)
  );

  llc_line_lock #(
    .num_sets (num_sets),
    .num_ways (num_ways)
  ) i_line_lock (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .lock_req_i     (lock_req),
    .lock_index_i   (lock_index),
    .lock_way_i     (lock_way),
    .unlock_valid_i (unlock_valid_i),
    .unlock_index_i (unlock_index_i),
    .unlock_way_i   (unlock_way_i),
    .locked_o       (locked)
  );

  llc_miss_counters #(
    .num_ids (num_ids)
  ) i_miss_counters (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .cnt_up_i      (cnt_up),
    .cnt_up_id_i   (cnt_up_id),
    .cnt_down_i    (cnt_down_valid_i),
    .cnt_down_id_i (cnt_down_id_i),
    .to_miss_o     (to_miss),
    .stall_o       (cnt_stall)
  );

  //////////////////////////////
  // shared result bus
  //////////////////////////////
  assign out_addr_o  = out_res.desc.addr;
  assign out_id_o    = out_res.desc.id;
  assign out_rw_o    = out_res.desc.rw;
  assign way_ind_o   = out_res.way_ind;
  // only a true miss refills, a hit sent down the miss port does not
  assign refill_o    = ~out_res.hit;
  assign evict_o     = out_res.evict;
  assign evict_tag_o = out_res.evict_tag;

endmodule

`default_nettype wire

//--- src/llc_hit_miss_pkg.sv
/*
  Geometry and descriptor types for the hit/miss stage.
  offset_width + index_width + tag_width must add up to addr_width.
*/
`default_nettype none

package llc_hit_miss_pkg;

  //////////////////////////////
  // cache geometry
  //////////////////////////////

  // byte address width
  parameter int unsigned addr_width   = 16;
  // set associativity
  parameter int unsigned num_ways     = 4;
  // set index bits, 16 sets
  parameter int unsigned index_width  = 4;
  // byte and block offset bits below the index
  parameter int unsigned offset_width = 4;
  // address bits above the index
  parameter int unsigned tag_width    = 8;
  // descriptor id width
  parameter int unsigned id_width     = 2;
  // miss counter width, saturates at all ones
  parameter int unsigned cnt_width    = 3;

  typedef logic [addr_width-1:0]  addr_t;
  typedef logic [index_width-1:0] index_t;
  typedef logic [tag_width-1:0]   tag_t;
  typedef logic [id_width-1:0]    id_t;
  // one-hot way select
  typedef logic [num_ways-1:0]    way_ind_t;

  //////////////////////////////
  // descriptors
  //////////////////////////////

  // incoming request, rw high means write
  typedef struct packed {
    addr_t addr;
    id_t   id;
    logic  rw;
  } desc_t;

  // descriptor after the tag lookup
  typedef struct packed {
    desc_t    desc;
    way_ind_t way_ind;
    logic     hit;
    logic     evict;
    tag_t     evict_tag;
  } result_t;

endpackage

`default_nettype wire

//--- src/llc_line_lock.sv
/*
  One lock bit per line. Lock and unlock of the same line in one cycle
  leave it locked. Unlock is never refused.
*/
`timescale 1ns/10ps
`default_nettype none

module llc_line_lock #(
  parameter int unsigned num_sets = 16,
  parameter int unsigned num_ways = 4
) (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       lock_req_i,
  input  llc_hit_miss_pkg::index_t   lock_index_i,
  input  llc_hit_miss_pkg::way_ind_t lock_way_i,
  input  logic                       unlock_valid_i,
  input  llc_hit_miss_pkg::index_t   unlock_index_i,
  input  llc_hit_miss_pkg::way_ind_t unlock_way_i,
  output logic                       locked_o
);
  import llc_hit_miss_pkg::*;

  logic [num_ways-1:0] lock_q [num_sets];
  logic [num_ways-1:0] lock_d [num_sets];

  // next state per set, unlock first so a same-cycle lock overrides it
  always_comb begin
    for (int s = 0; s < num_sets; s++) begin
      lock_d[s] = lock_q[s];
      if (unlock_valid_i && (unlock_index_i == index_t'(s))) begin
        lock_d[s] = lock_d[s] & ~unlock_way_i;
      end
      if (lock_req_i && (lock_index_i == index_t'(s))) begin
        lock_d[s] = lock_d[s] | lock_way_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int s = 0; s < num_sets; s++) begin
        lock_q[s] <= '0;
      end
    end else begin
      for (int s = 0; s < num_sets; s++) begin
        lock_q[s] <= lock_d[s];
      end
    end
  end

  // state of the line the current result points at
  assign locked_o = |(lock_q[lock_index_i] & lock_way_i);

endmodule

`default_nettype wire

//--- src/llc_miss_counters.sv
/*
  Saturating count per ID of descriptors sitting in the miss path.
  Both outputs look at the ID on cnt_up_id_i, the one about to dispatch.
*/
`timescale 1ns/10ps
`default_nettype none

module llc_miss_counters #(
  parameter int unsigned num_ids = 4
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  cnt_up_i,
  input  llc_hit_miss_pkg::id_t cnt_up_id_i,
  input  logic                  cnt_down_i,
  input  llc_hit_miss_pkg::id_t cnt_down_id_i,
  output logic                  to_miss_o,
  output logic                  stall_o
);
  import llc_hit_miss_pkg::*;

  localparam logic [cnt_width-1:0] cnt_max = '1;

  logic [cnt_width-1:0] cnt_q [num_ids];
  logic [num_ids-1:0]   up_hit;
  logic [num_ids-1:0]   down_hit;

  // decode which counter each event addresses
  always_comb begin
    for (int i = 0; i < num_ids; i++) begin
      up_hit[i]   = cnt_up_i && (cnt_up_id_i == id_t'(i));
      down_hit[i] = cnt_down_i && (cnt_down_id_i == id_t'(i));
    end
  end

  //////////////////////////////
  // counters
  //////////////////////////////
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < num_ids; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < num_ids; i++) begin
        // up and down together cancel
        if (up_hit[i] && !down_hit[i] && (cnt_q[i] != cnt_max)) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end else if (down_hit[i] && !up_hit[i] && (cnt_q[i] != '0)) begin
          cnt_q[i] <= cnt_q[i] - 1'b1;
        end
      end
    end
  end

  assign to_miss_o = (cnt_q[cnt_up_id_i] != '0);
  // a full counter could not record one more miss
  assign stall_o   = (cnt_q[cnt_up_id_i] == cnt_max);

endmodule

`default_nettype wire

//--- src/llc_stage_if.sv
/*
  Valid/ready links inside the stage. A beat moves when valid and ready
  are both high at a clock edge; the payload holds while valid waits.
*/
`timescale 1ns/10ps
`default_nettype none

// intake to tag store
interface llc_req_if;
  import llc_hit_miss_pkg::*;
  logic  valid;
  logic  ready;
  desc_t desc;
  modport source (output valid, output desc, input ready);
  modport sink   (input valid, input desc, output ready);
endinterface

// tag store to dispatch
interface llc_res_if;
  import llc_hit_miss_pkg::*;
  logic    valid;
  logic    ready;
  result_t res;
  modport source (output valid, output res, input ready);
  modport sink   (input valid, input res, output ready);
endinterface

`default_nettype wire

//--- src/llc_tag_store.sv
/*
  Tag, valid and dirty arrays with a one-hot round-robin pointer per set.
  After reset the sets are cleared one per cycle and requests are refused.
  num_ways must be at least 2; num_sets must be 2**index_width.
*/
`timescale 1ns/10ps
`default_nettype none

module llc_tag_store #(
  parameter int unsigned num_sets = 16,
  parameter int unsigned num_ways = 4
) (
  input  logic      clk_i,
  input  logic      rst_i,
  llc_req_if.sink   req_i,
  llc_res_if.source res_o
);
  import llc_hit_miss_pkg::*;

  localparam int unsigned way_bits = $clog2(num_ways);

  // line state, no reset, cleared by the walk below
  tag_t                tag_q   [num_sets][num_ways];
  logic [num_ways-1:0] valid_q [num_sets];
  logic [num_ways-1:0] dirty_q [num_sets];
  logic [num_ways-1:0] rr_q    [num_sets];

  // clear walk
  logic   clearing_q;
  index_t clr_idx_q;

  // lookup
  index_t              idx;
  tag_t                tag;
  logic [num_ways-1:0] hit_vec;
  logic [num_ways-1:0] inv_sel;
  logic [num_ways-1:0] way_sel;
  logic [way_bits-1:0] way_num;
  logic                hit;
  logic                use_rr;
  logic                old_dirty;
  logic                new_dirty;
  logic                req_xfer;

  // result register
  logic    res_valid_q;
  result_t res_q;

  assign idx = req_i.desc.addr[offset_width +: index_width];
  assign tag = req_i.desc.addr[offset_width + index_width +: tag_width];

  //////////////////////////////
  // lookup and way choice
  //////////////////////////////
  always_comb begin
    hit_vec = '0;
    inv_sel = '0;
    way_num = '0;
    for (int w = 0; w < num_ways; w++) begin
      hit_vec[w] = valid_q[idx][w] && (tag_q[idx][w] == tag);
    end
    // scan downwards so the lowest invalid way is the one left standing
    for (int w = num_ways - 1; w >= 0; w--) begin
      if (!valid_q[idx][w]) begin
        inv_sel    = '0;
        inv_sel[w] = 1'b1;
      end
    end
    hit    = |hit_vec;
    use_rr = !hit && !(|inv_sel);
    // hit way, else first free way, else the set's victim pointer
    if (hit) begin
      way_sel = hit_vec;
    end else if (!use_rr) begin
      way_sel = inv_sel;
    end else begin
      way_sel = rr_q[idx];
    end
    for (int w = 0; w < num_ways; w++) begin
      if (way_sel[w]) begin
        way_num = way_bits'(w);
      end
    end
    old_dirty = |(way_sel & dirty_q[idx]);
    // a write hit keeps the line dirty, a refill starts from the write bit
    new_dirty = req_i.desc.rw | (hit & old_dirty);
  end

  // result slot is free or emptying, and the clear is done
  assign req_i.ready = !clearing_q && (!res_valid_q || res_o.ready);
  assign req_xfer    = req_i.valid && req_i.ready;

  //////////////////////////////
  // array update
  //////////////////////////////
  always_ff @(posedge clk_i) begin
    if (clearing_q) begin
      valid_q[clr_idx_q] <= '0;
      dirty_q[clr_idx_q] <= '0;
      rr_q[clr_idx_q]    <= num_ways'(1);
    end else if (req_xfer) begin
      tag_q[idx][way_num] <= tag;
      valid_q[idx]        <= valid_q[idx] | way_sel;
      dirty_q[idx]        <= (dirty_q[idx] & ~way_sel) | (way_sel & {num_ways{new_dirty}});
      // pointer only moves when it actually picked the victim
      if (use_rr) begin
        rr_q[idx] <= {rr_q[idx][num_ways-2:0], rr_q[idx][num_ways-1]};
      end
    end
  end

  // control, clear walk restarts on every reset
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      clearing_q  <= 1'b1;
      clr_idx_q   <= '0;
      res_valid_q <= 1'b0;
    end else begin
      if (clearing_q) begin
        clr_idx_q <= clr_idx_q + index_t'(1);
        if (clr_idx_q == index_t'(num_sets - 1)) begin
          clearing_q <= 1'b0;
        end
      end
      if (req_xfer) begin
        res_valid_q <= 1'b1;
      end else if (res_o.ready) begin
        res_valid_q <= 1'b0;
      end
    end
  end

  // evict only when a miss displaces a valid dirty line
  always_ff @(posedge clk_i) begin
    if (req_xfer) begin
      res_q.desc      <= req_i.desc;
      res_q.way_ind   <= way_sel;
      res_q.hit       <= hit;
      res_q.evict     <= !hit && old_dirty && |(way_sel & valid_q[idx]);
      res_q.evict_tag <= tag_q[idx][way_num];
    end
  end

  assign res_o.valid = res_valid_q;
  assign res_o.res   = res_q;

endmodule

`default_nettype wire

//--- verification/llc_hit_miss_tasks.svh
/*
  Drive, compare and test tasks, included inside the testbench module.
  They rely on the DUT signals and model state declared there.
*/
`ifndef llc_hit_miss_tasks_svh
`define llc_hit_miss_tasks_svh

task automatic report_failure(input string msg);
  $display("%s", msg);
  $display("sim failed");
  $fatal(1);
endtask

function automatic string format_result(result_t r);
  return $sformatf("addr %h id %0d rw %b way %b refill %b evict %b tag %h",
                   r.desc.addr, r.desc.id, r.desc.rw, r.way_ind, !r.hit, r.evict, r.evict_tag);
endfunction

// evict_tag only counts when an eviction is expected
task automatic compare_result(input result_t got, input result_t exp, input string what);
  if (!exp.evict) begin
    got.evict_tag = exp.evict_tag;
  end
  if (got !== exp) begin
    report_failure($sformatf("MISMATCH at %0t: %s got %s, expected %s", $time, what,
                             format_result(got), format_result(exp)));
  end
endtask

task automatic compare_port(input logic got_hit, input logic exp_hit, input string what);
  if (got_hit !== exp_hit) begin
    report_failure($sformatf("MISMATCH at %0t: %s left on the %s port, expected the %s port",
                             $time, what, got_hit ? "hit" : "miss", exp_hit ? "hit" : "miss"));
  end
endtask

//////////////////////////////
// drive helpers
//////////////////////////////

// to the next drive point, 1 ns after the rising edge
task automatic step();
  @(posedge clk_i);
  #1;
endtask

function automatic addr_t make_addr(tag_t t, int s);
  // random offset bits, the lookup must ignore them
  return {t, index_t'(s), offset_width'($urandom)};
endfunction

// shared result bus as the DUT presents it, refill low means hit
function automatic result_t sample_bus();
  result_t r;
  r.desc.addr = out_addr_o;
  r.desc.id   = out_id_o;
  r.desc.rw   = out_rw_o;
  r.way_ind   = way_ind_o;
  r.hit       = ~refill_o;
  r.evict     = evict_o;
  r.evict_tag = evict_tag_o;
  return r;
endfunction

// hold valid until the input takes it
task automatic send(input addr_t a, input id_t id, input logic rw);
  logic r;
  valid_i = 1'b1;
  addr_i  = a;
  id_i    = id;
  rw_i    = rw;
  do begin
    @(negedge clk_i);
    r = ready_o;
    if (!r) begin
      ready_low_seen = 1'b1;
    end
    step();
  end while (!r);
  valid_i = 1'b0;
endtask

task automatic issue(input addr_t a, input id_t id, input logic rw);
  exp_q.push_back(predict(a, id, rw));
  send(a, id, rw);
endtask

// one cycle pulse of unlock and count-down, an empty way mask skips the unlock
task automatic release_line(input int s, input way_ind_t way, input logic down, input id_t id);
  unlock_valid_i   = |way;
  unlock_index_i   = index_t'(s);
  unlock_way_i     = way;
  cnt_down_valid_i = down;
  cnt_down_id_i    = id;
  step();
  unlock_valid_i   = 1'b0;
  cnt_down_valid_i = 1'b0;
  if (down && m_cnt[id] > 0) begin
    m_cnt[id]--;
  end
endtask

task automatic count_down(input id_t id);
  release_line(0, '0, 1'b1, id);
endtask

task automatic expect_quiet(input int n, input string what);
  repeat (n) begin
    @(negedge clk_i);
    if (hit_valid_o || miss_valid_o) begin
      report_failure(what);
    end
    step();
  end
endtask

// wait for the next port transfer with both readies high, then check it
task automatic collect(input string what, input logic unlock, input logic down);
  result_t got;
  result_t exp;
  logic    got_hit;
  logic    exp_hit;
  logic    seen;
  int      s;
  do begin
    @(negedge clk_i);
    if (hit_valid_o && miss_valid_o) begin
      report_failure("hit and miss port valids are high together");
    end
    seen    = hit_valid_o | miss_valid_o;
    got_hit = hit_valid_o;
    got     = sample_bus();
    step();
  end while (!seen);
  exp     = exp_q.pop_front();
  s       = set_of(exp.desc.addr);
  exp_hit = exp.hit && (m_cnt[exp.desc.id] == 0);
  compare_port(got_hit, exp_hit, what);
  compare_result(got, exp, what);
  // a miss-port dispatch counts as a miss in flight
  if (!exp_hit && m_cnt[exp.desc.id] < cnt_max) begin
    m_cnt[exp.desc.id]++;
  end
  if (unlock || down) begin
    release_line(s, unlock ? exp.way_ind : way_ind_t'(0), down, exp.desc.id);
  end
endtask

task automatic access(input addr_t a, input id_t id, input logic rw, input logic unlock,
                      input logic down, input string what);
  issue(a, id, rw);
  collect(what, unlock, down);
endtask

// hit port consumer with random stall stretches
task automatic drain_with_stalls(input int n);
  result_t got;
  result_t prev;
  result_t exp;
  logic    seen;
  logic    v;
  logic    xfer;
  int      wait_len;
  int      waited;
  for (int i = 0; i < n; i++) begin
    wait_len    = 2 + int'($urandom % 4);
    waited      = 0;
    seen        = 1'b0;
    xfer        = 1'b0;
    hit_ready_i = 1'b0;
    while (!xfer) begin
      @(negedge clk_i);
      if (miss_valid_o) begin
        report_failure("a hit in the stream left on the miss port");
      end
      v    = hit_valid_o;
      xfer = v && hit_ready_i;
      got  = sample_bus();
      if (v && seen && got !== prev) begin
        report_failure($sformatf("MISMATCH at %0t: held result changed from %s to %s", $time,
                                 format_result(prev), format_result(got)));
      end
      if (v) begin
        prev = got;
        seen = 1'b1;
      end
      step();
      if (v && !xfer) begin
        waited++;
        if (waited >= wait_len) begin
          hit_ready_i = 1'b1;
        end
      end
    end
    // closed again before the unlock cycle
    hit_ready_i = 1'b0;
    exp = exp_q.pop_front();
    compare_result(got, exp, "back-pressure stream");
    release_line(set_of(exp.desc.addr), exp.way_ind, 1'b0, exp.desc.id);
  end
  hit_ready_i = 1'b1;
endtask

//////////////////////////////
// directed tests
//////////////////////////////

task automatic clear_and_fill();
  tag_t base;
  for (int i = 0; i < num_sets; i++) begin
    @(negedge clk_i);
    if (ready_o !== 1'b0 || hit_valid_o !== 1'b0 || miss_valid_o !== 1'b0) begin
      report_failure("ready_o or a port valid was high during the tag clear");
    end
    step();
  end
  base = tag_t'($urandom % 200);
  for (int k = 0; k < num_ways; k++) begin
    set_a_tags[k] = tag_t'(base + k);
    access(make_addr(set_a_tags[k], 1), id_t'(k), 1'b0, 1'b1, 1'b1, "first fill");
  end
endtask

task automatic repeat_hits();
  for (int k = 0; k < num_ways; k++) begin
    access(make_addr(set_a_tags[k], 1), id_t'(k), 1'b0, 1'b1, 1'b0, "repeat hit");
  end
endtask

task automatic dirty_eviction();
  tag_t base;
  base = tag_t'($urandom % 200);
  // dirty fill, then four misses walk the victim pointer
  for (int k = 0; k < 2 * num_ways; k++) begin
    access(make_addr(tag_t'(base + k), 2), 2'd0, k < num_ways, 1'b1, 1'b1, "dirty set");
  end
  // clean fill, its victim goes without eviction
  for (int k = 0; k <= num_ways; k++) begin
    access(make_addr(tag_t'(base + k), 3), 2'd1, 1'b0, 1'b1, 1'b1, "clean set");
  end
endtask

task automatic lock_hold();
  addr_t a;
  a = make_addr(set_a_tags[0], 1);
  access(a, 2'd0, 1'b1, 1'b0, 1'b0, "lock owner");
  issue(a, 2'd0, 1'b0);
  expect_quiet(12, "a result left while its line was locked");
  release_line(1, exp_q[0].way_ind, 1'b0, 2'd0);
  collect("after unlock", 1'b1, 1'b0);
endtask

task automatic outstanding_misses();
  tag_t  base;
  addr_t a;
  base = tag_t'($urandom % 200);
  a    = make_addr(base, 4);
  access(a, 2'd1, 1'b0, 1'b1, 1'b0, "miss left outstanding");
  access(a, 2'd1, 1'b0, 1'b1, 1'b0, "hit behind a miss");
  count_down(2'd1);
  count_down(2'd1);
  access(a, 2'd1, 1'b0, 1'b1, 1'b0, "hit after count-down");
  // seven misses fill the counter, the eighth must wait
  for (int k = 1; k < 8; k++) begin
    access(make_addr(tag_t'(base + k), 5), 2'd2, 1'b0, 1'b1, 1'b0, "miss toward saturation");
  end
  issue(make_addr(tag_t'(base + 8), 5), 2'd2, 1'b0);
  expect_quiet(12, "the eighth outstanding miss was not stalled");
  count_down(2'd2);
  collect("stalled miss", 1'b1, 1'b0);
  while (m_cnt[2] > 0) begin
    count_down(2'd2);
  end
endtask

task automatic back_pressure();
  tag_t base;
  base = tag_t'($urandom % 200);
  for (int k = 0; k < 2 * num_ways; k++) begin
    access(make_addr(tag_t'(base + k % num_ways), 6 + k / num_ways), id_t'(k), 1'b0,
           1'b1, 1'b1, "stream fill");
  end
  ready_low_seen = 1'b0;
  fork
    begin
      for (int k = 0; k < 2 * num_ways; k++) begin
        issue(make_addr(tag_t'(base + k % num_ways), 6 + k / num_ways), id_t'(k),
              logic'($urandom % 2));
      end
    end
    drain_with_stalls(2 * num_ways);
  join
  if (!ready_low_seen) begin
    report_failure("ready_o never dropped while the hit port was stalled");
  end
  expect_quiet(4, "an extra result appeared after the stream");
endtask

`endif

//--- verification/llc_hit_miss_tb.sv
/*
  Directed testbench for the hit/miss stage. Inputs change 1 ns after the
  rising edge and outputs are sampled at the falling edge. Stops at the
  first error; a cycle counter bounds the whole run.
*/
`timescale 1ns/10ps
`default_nettype none

module llc_hit_miss_tb;
  import llc_hit_miss_pkg::*;

  localparam int num_sets       = 2 ** index_width;
  localparam int num_ids        = 2 ** id_width;
  localparam int cnt_max        = 2 ** cnt_width - 1;
  localparam int num_tests      = 6;
  // each test stays well inside 200 cycles, plus the tag clear
  localparam int timeout_cycles = num_tests * 200 + num_sets;

  // DUT ports
  logic     clk_i = 1'b0;
  logic     rst_i;
  logic     valid_i;
  logic     ready_o;
  addr_t    addr_i;
  id_t      id_i;
  logic     rw_i;
  logic     hit_valid_o;
  logic     hit_ready_i;
  logic     miss_valid_o;
  logic     miss_ready_i;
  addr_t    out_addr_o;
  id_t      out_id_o;
  logic     out_rw_o;
  way_ind_t way_ind_o;
  logic     refill_o;
  logic     evict_o;
  tag_t     evict_tag_o;
  logic     unlock_valid_i;
  index_t   unlock_index_i;
  way_ind_t unlock_way_i;
  logic     cnt_down_valid_i;
  id_t      cnt_down_id_i;

  //////////////////////////////
  // reference model state
  //////////////////////////////
  tag_t    m_tag   [num_sets][num_ways];
  logic    m_valid [num_sets][num_ways];
  logic    m_dirty [num_sets][num_ways];
  // victim way per set, as a plain way number
  int      m_rr    [num_sets];
  int      m_cnt   [num_ids];
  // expected results in lookup order
  result_t exp_q   [$];

  int   cycles = 0;
  logic ready_low_seen;
  // tags of the first filled set, reused by later tests
  tag_t set_a_tags [num_ways];

  llc_hit_miss i_llc_hit_miss (.*);

  always #4 clk_i = ~clk_i;

  function automatic void clear_model();
    for (int s = 0; s < num_sets; s++) begin
      m_rr[s] = 0;
      for (int w = 0; w < num_ways; w++) begin
        m_valid[s][w] = 1'b0;
        m_dirty[s][w] = 1'b0;
      end
    end
    for (int i = 0; i < num_ids; i++) begin
      m_cnt[i] = 0;
    end
  endfunction

  // set number of a byte address
  function automatic int set_of(addr_t a);
    return int'(a[offset_width +: index_width]);
  endfunction

  // lookup and tag update of one descriptor, in lookup order
  function automatic result_t predict(addr_t a, id_t id, logic rw);
    result_t r;
    int      s;
    int      w;
    tag_t    t;
    s = set_of(a);
    t = a[addr_width-1 -: tag_width];
    w = -1;
    r = '0;
    r.desc.addr = a;
    r.desc.id   = id;
    r.desc.rw   = rw;
    for (int k = 0; k < num_ways; k++) begin
      if (m_valid[s][k] && m_tag[s][k] == t) begin
        w = k;
      end
    end
    r.hit = (w >= 0);
    if (!r.hit) begin
      // first free way counting up from way 0
      for (int k = 0; k < num_ways; k++) begin
        if (w < 0 && !m_valid[s][k]) begin
          w = k;
        end
      end
      // full set, take the victim and move the pointer on
      if (w < 0) begin
        w           = m_rr[s];
        m_rr[s]     = (m_rr[s] + 1) % num_ways;
        r.evict     = m_dirty[s][w];
        r.evict_tag = m_tag[s][w];
      end
    end
    r.way_ind     = way_ind_t'(1) << w;
    m_dirty[s][w] = rw | (r.hit & m_dirty[s][w]);
    m_tag[s][w]   = t;
    m_valid[s][w] = 1'b1;
    return r;
  endfunction

  `include "llc_hit_miss_tasks.svh"

  // watchdog
  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= timeout_cycles) begin
      report_failure($sformatf("timeout: the run did not finish in %0d cycles", timeout_cycles));
    end
  end

  initial begin
    void'($urandom(43439));
    rst_i            = 1'b1;
    valid_i          = 1'b0;
    addr_i           = '0;
    id_i             = '0;
    rw_i             = 1'b0;
    hit_ready_i      = 1'b1;
    miss_ready_i     = 1'b1;
    unlock_valid_i   = 1'b0;
    unlock_index_i   = '0;
    unlock_way_i     = '0;
    cnt_down_valid_i = 1'b0;
    cnt_down_id_i    = '0;
    ready_low_seen   = 1'b0;
    clear_model();
    repeat (2) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    clear_and_fill();
    repeat_hits();
    dirty_eviction();
    lock_hold();
    outstanding_misses();
    back_pressure();
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire
